//--- list.f
common/CorePkg.sv
rtl/FetchStage.sv
decode/RegFile.sv
decode/DecodeStage.sv
rtl/ExecuteStage.sv
rtl/MemoryStage.sv
rtl/HazardUnit.sv
rtl/PipeCore.sv
verification/ClockGen.sv
verification/PipeCore_properties.sv
verification/PipeCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= PipeCoreTb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/PipeCoreTb.sv
`timescale 1ns/1ps

module PipeCoreTb;

    localparam int RESET_CYCLES     = 16;
    localparam int CYCLES_PER_ENTRY = 40;
    localparam int PARK_CYCLES      = 20;
    localparam int CHAIN_LEN        = 12;
    localparam int NUM_TESTS        = 5;

    // one program word and the retire it should produce, if any.
    typedef struct packed {
        logic [31:0] word;
        logic        runId;
        logic [2:0]  testId;
        logic        retires;
        logic [4:0]  rd;
        logic [31:0] value;
    } ProgEntry_t;

    logic                            i_Clk;
    logic                            i_rst;
    logic                            i_ImemWe;
    logic [CorePkg::IMEM_ADDR_W-1:0] i_ImemAddr;
    logic [CorePkg::XLEN-1:0]        i_ImemData;
    CorePkg::RetireInfo_t            o_Retire;

    ProgEntry_t progTable [$];
    string      testNames [NUM_TESTS];
    int         testErrors [NUM_TESTS];
    int         errorCount;
    int         testsPassed;
    int         testsFailed;
    int         watchdogCycles;

    ClockGen ClockGen_i (
        .o_Clk (i_Clk)
    );

    PipeCore PipeCore_i (
        .i_Clk      (i_Clk),
        .i_rst      (i_rst),
        .i_ImemWe   (i_ImemWe),
        .i_ImemAddr (i_ImemAddr),
        .i_ImemData (i_ImemData),
        .o_Retire   (o_Retire)
    );

    bind HazardUnit PipeCore_properties PipeCore_properties_i (
        .i_Clk       (PipeCoreTb.i_Clk),
        .i_rst       (PipeCoreTb.i_rst),
        .i_Rs1Addr   (i_Rs1Addr),
        .i_Rs1Valid  (i_Rs1Valid),
        .i_Rs2Addr   (i_Rs2Addr),
        .i_Rs2Valid  (i_Rs2Valid),
        .i_DecodeReg (i_DecodeReg),
        .i_ExecReg   (i_ExecReg),
        .i_Wb        (i_Wb),
        .i_Ctl       (o_Ctl)
    );

    // instruction encoders, field layouts as in the RV32I base ISA.
    function automatic logic [31:0] encodeAddi(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, CorePkg::OP_ITYPE};
    endfunction

    function automatic logic [31:0] encodeRType(input logic [6:0] funct7, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        return {funct7, rs2, rs1, 3'b000, rd, CorePkg::OP_RTYPE};
    endfunction

    function automatic logic [31:0] encodeLw(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, CorePkg::OP_LOAD};
    endfunction

    function automatic logic [31:0] encodeSw(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], CorePkg::OP_STORE};
    endfunction

    function automatic logic [31:0] encodeBeq(input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, 3'b000, offset[4:1], offset[11],
                CorePkg::OP_BRANCH};
    endfunction

    function automatic void addEntry(input logic runId, input logic [2:0] testId,
                                     input logic [31:0] word, input logic retires,
                                     input logic [4:0] rd, input logic [31:0] value);
        ProgEntry_t entry;
        entry.word    = word;
        entry.runId   = runId;
        entry.testId  = testId;
        entry.retires = retires;
        entry.rd      = rd;
        entry.value   = value;
        progTable.push_back(entry);
    endfunction

    task automatic buildTables();
        logic [11:0] imm;
        logic [31:0] runningSum;
        // first run covers tests 1 to 4 in one program.
        addEntry(1'b0, 3'd0, encodeAddi(5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 32'd5);
        addEntry(1'b0, 3'd0, encodeAddi(5'd2, 5'd0, 12'd7), 1'b1, 5'd2, 32'd7);
        addEntry(1'b0, 3'd1, encodeRType(7'b0000000, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'd12);
        addEntry(1'b0, 3'd2, encodeSw(5'd3, 5'd0, 12'd0), 1'b0, 5'd0, 32'd0);
        addEntry(1'b0, 3'd2, encodeLw(5'd4, 5'd0, 12'd0), 1'b1, 5'd4, 32'd12);
        addEntry(1'b0, 3'd2, encodeRType(7'b0100000, 5'd5, 5'd4, 5'd1), 1'b1, 5'd5, 32'd7);
        addEntry(1'b0, 3'd3, encodeBeq(5'd5, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0);
        // skipped by the branch, so it has no retire.
        addEntry(1'b0, 3'd3, encodeAddi(5'd6, 5'd0, 12'd99), 1'b0, 5'd0, 32'd0);
        addEntry(1'b0, 3'd3, encodeAddi(5'd7, 5'd0, 12'd1), 1'b1, 5'd7, 32'd1);
        addEntry(1'b0, 3'd3, encodeBeq(5'd0, 5'd0, 13'd0), 1'b0, 5'd0, 32'd0);
        // these would retire only if the park branch fell through.
        addEntry(1'b0, 3'd3, encodeAddi(5'd8, 5'd0, 12'd3), 1'b0, 5'd0, 32'd0);
        addEntry(1'b0, 3'd3, encodeAddi(5'd9, 5'd0, 12'd4), 1'b0, 5'd0, 32'd0);
        runningSum = '0;
        for (int k = 0; k < CHAIN_LEN; k++) begin
            imm        = 12'($urandom);
            runningSum = runningSum + {{20{imm[11]}}, imm};
            addEntry(1'b1, 3'd4, encodeAddi(5'(k + 1), 5'(k), imm), 1'b1, 5'(k + 1),
                     runningSum);
        end
        addEntry(1'b1, 3'd4, encodeBeq(5'd0, 5'd0, 13'd0), 1'b0, 5'd0, 32'd0);
        addEntry(1'b1, 3'd4, encodeAddi(5'd0, 5'd0, 12'd0), 1'b0, 5'd0, 32'd0);
        addEntry(1'b1, 3'd4, encodeAddi(5'd0, 5'd0, 12'd0), 1'b0, 5'd0, 32'd0);
    endtask

    // the program is written through the load port while reset is held.
    task automatic loadProgram(input logic runId);
        ProgEntry_t image [$];
        for (int idx = 0; idx < progTable.size(); idx++) begin
            if (progTable[idx].runId == runId) begin
                image.push_back(progTable[idx]);
            end
        end
        @(posedge i_Clk);
        i_rst <= 1'b1;
        for (int cyc = 0; cyc < RESET_CYCLES; cyc++) begin
            if (cyc < image.size()) begin
                i_ImemWe   <= 1'b1;
                i_ImemAddr <= cyc[CorePkg::IMEM_ADDR_W-1:0];
                i_ImemData <= image[cyc].word;
            end else begin
                i_ImemWe <= 1'b0;
            end
            @(posedge i_Clk);
        end
        i_ImemWe <= 1'b0;
        i_rst    <= 1'b0;
    endtask

    task automatic waitRetire(output CorePkg::RetireInfo_t seen);
        do begin
            @(negedge i_Clk);
        end while (!o_Retire.valid);
        seen = o_Retire;
    endtask

    task automatic checkValue(input int testIdx, input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t ns: test %0d %s expected %h, got %h", $time, testIdx + 1,
                     what, expected, got);
            errorCount++;
            testErrors[testIdx]++;
        end
    endtask

    task automatic reportTest(input int testIdx);
        if (testErrors[testIdx] == 0) begin
            testsPassed++;
            $display("test %0d (%s): passed", testIdx + 1, testNames[testIdx]);
        end else begin
            testsFailed++;
            $display("test %0d (%s): %0d mismatches", testIdx + 1, testNames[testIdx],
                     testErrors[testIdx]);
        end
    endtask

    task automatic runProgram(input logic runId);
        ProgEntry_t           entry;
        CorePkg::RetireInfo_t seen;
        int                   curTest;
        int                   extra;
        loadProgram(runId);
        curTest = -1;
        for (int idx = 0; idx < progTable.size(); idx++) begin
            entry = progTable[idx];
            if (entry.runId == runId && entry.retires) begin
                if (curTest >= 0 && curTest != int'(entry.testId)) begin
                    reportTest(curTest);
                end
                curTest = int'(entry.testId);
                waitRetire(seen);
                checkValue(curTest, "retire rd", 32'(seen.rd), 32'(entry.rd));
                checkValue(curTest, "retire value", seen.value, entry.value);
            end
        end
        if (runId == 1'b0) begin
            // the core is parked on its own branch and must stay quiet.
            extra = 0;
            repeat (PARK_CYCLES) begin
                @(negedge i_Clk);
                if (o_Retire.valid) begin
                    extra++;
                end
            end
            checkValue(curTest, "retires after park", 32'(extra), 32'd0);
        end
        reportTest(curTest);
    endtask

    initial begin
        i_rst       = 1'b1;
        i_ImemWe    = 1'b0;
        i_ImemAddr  = '0;
        i_ImemData  = '0;
        errorCount  = 0;
        testsPassed = 0;
        testsFailed = 0;
        testErrors  = '{default: 0};
        testNames   = '{"independent ALU", "ALU read-after-write", "store, load and load-use",
                        "taken branch and park", "random ADDI chain"};
        void'($urandom(32'hd2d));
        buildTables();
        watchdogCycles = CYCLES_PER_ENTRY * progTable.size() + 2 * (RESET_CYCLES + 1)
                         + PARK_CYCLES;
        runProgram(1'b0);
        runProgram(1'b1);
        $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge i_Clk);
        $display("timeout: the expected retires did not all arrive within %0d cycles",
                 watchdogCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- verification/PipeCore_properties.sv
`timescale 1ns/1ps

module PipeCore_properties (
    input logic                           i_Clk,
    input logic                           i_rst,
    input logic [CorePkg::REG_ADDR_W-1:0] i_Rs1Addr,
    input logic                           i_Rs1Valid,
    input logic [CorePkg::REG_ADDR_W-1:0] i_Rs2Addr,
    input logic                           i_Rs2Valid,
    input CorePkg::DecodeReg_t            i_DecodeReg,
    input CorePkg::ExecReg_t              i_ExecReg,
    input CorePkg::WbReg_t                i_Wb,
    input CorePkg::HazardCtl_t            i_Ctl
);

    logic takenBranch;
    logic srcStall;

    // true when an older instruction in execute, memory or writeback still owes addr a write.
    function automatic logic writePending(
        input logic [CorePkg::REG_ADDR_W-1:0] addr,
        input CorePkg::DecodeReg_t            exStage,
        input CorePkg::ExecReg_t              memStage,
        input CorePkg::WbReg_t                wbStage
    );
        return (addr != '0)
            && ((exStage.valid && exStage.writesReg && (exStage.rd == addr))
                || (memStage.valid && memStage.writesReg && (memStage.rd == addr))
                || (wbStage.valid && wbStage.writesReg && (wbStage.rd == addr)));
    endfunction

    assign takenBranch = i_ExecReg.valid && i_ExecReg.takeBranch;
    assign srcStall    = (i_Rs1Valid && writePending(i_Rs1Addr, i_DecodeReg, i_ExecReg, i_Wb))
                      || (i_Rs2Valid && writePending(i_Rs2Addr, i_DecodeReg, i_ExecReg, i_Wb));

    // a taken branch in memory leaves the three younger stages empty.
    flushEmptiesStages: assert property (@(posedge i_Clk) disable iff (i_rst)
        takenBranch
        |=> (!i_DecodeReg.valid && !i_ExecReg.valid && !i_Rs1Valid && !i_Rs2Valid))
        else $error("wrong-path instruction survived a taken branch");

    stallHoldsPc: assert property (@(posedge i_Clk) disable iff (i_rst)
        (!i_Ctl.pcEn) == (srcStall && !takenBranch))
        else $error("pcEn does not follow the stall condition");

    // once reset has cleared every stage there is nothing to stall or flush.
    resetIdle: assert property (@(posedge i_Clk)
        (i_rst && $past(i_rst))
        |-> (i_Ctl.pcEn && i_Ctl.enFetchReg && i_Ctl.enDecodeReg && !i_Ctl.clrFetchReg
             && !i_Ctl.clrDecodeReg && !i_Ctl.clrExecReg))
        else $error("hazard control is not idle during reset");

endmodule

//--- verification/ClockGen.sv
`timescale 1ns/1ps

module ClockGen (
    output logic o_Clk
);

    // half of the 4 ns period.
    localparam int HALF_PERIOD = 2;

    initial begin
        o_Clk = 1'b0;
        forever begin
            #HALF_PERIOD o_Clk = ~o_Clk;
        end
    end

endmodule

//--- rtl/PipeCore.sv
`timescale 1ns/1ps

module PipeCore (
    input  logic                            i_Clk,
    input  logic                            i_rst,
    input  logic                            i_ImemWe,
    input  logic [CorePkg::IMEM_ADDR_W-1:0] i_ImemAddr,
    input  logic [CorePkg::XLEN-1:0]        i_ImemData,
    output CorePkg::RetireInfo_t            o_Retire
);

    CorePkg::HazardCtl_t            ctl;
    CorePkg::FetchReg_t             fetchReg;
    CorePkg::DecodeReg_t            decodeReg;
    CorePkg::ExecReg_t              execReg;
    CorePkg::WbReg_t                wbReg;
    logic [CorePkg::REG_ADDR_W-1:0] rs1Addr;
    logic                           rs1Valid;
    logic [CorePkg::REG_ADDR_W-1:0] rs2Addr;
    logic                           rs2Valid;

    FetchStage FetchStage_i (
        .i_Clk      (i_Clk),
        .i_rst      (i_rst),
        .i_ImemWe   (i_ImemWe),
        .i_ImemAddr (i_ImemAddr),
        .i_ImemData (i_ImemData),
        .i_Ctl      (ctl),
        .i_Redirect (execReg.takeBranch),
        .i_Target   (execReg.branchTarget),
        .o_FetchReg (fetchReg)
    );

    DecodeStage DecodeStage_i (
        .i_Clk       (i_Clk),
        .i_rst       (i_rst),
        .i_FetchReg  (fetchReg),
        .i_Ctl       (ctl),
        .i_Wb        (wbReg),
        .o_Rs1Addr   (rs1Addr),
        .o_Rs1Valid  (rs1Valid),
        .o_Rs2Addr   (rs2Addr),
        .o_Rs2Valid  (rs2Valid),
        .o_DecodeReg (decodeReg)
    );

    ExecuteStage ExecuteStage_i (
        .i_Clk       (i_Clk),
        .i_rst       (i_rst),
        .i_DecodeReg (decodeReg),
        .i_Ctl       (ctl),
        .o_ExecReg   (execReg)
    );

    MemoryStage MemoryStage_i (
        .i_Clk     (i_Clk),
        .i_rst     (i_rst),
        .i_ExecReg (execReg),
        .o_Wb      (wbReg)
    );

    HazardUnit HazardUnit_i (
        .i_Rs1Addr   (rs1Addr),
        .i_Rs1Valid  (rs1Valid),
        .i_Rs2Addr   (rs2Addr),
        .i_Rs2Valid  (rs2Valid),
        .i_DecodeReg (decodeReg),
        .i_ExecReg   (execReg),
        .i_Wb        (wbReg),
        .o_Ctl       (ctl)
    );

    // an instruction retires when it writes a real register in writeback.
    assign o_Retire.valid = wbReg.valid && wbReg.writesReg && (wbReg.rd != '0);
    assign o_Retire.rd    = wbReg.rd;
    assign o_Retire.value = wbReg.value;

endmodule

//--- rtl/HazardUnit.sv
`timescale 1ns/1ps

module HazardUnit (
    input  logic [CorePkg::REG_ADDR_W-1:0] i_Rs1Addr,
    input  logic                           i_Rs1Valid,
    input  logic [CorePkg::REG_ADDR_W-1:0] i_Rs2Addr,
    input  logic                           i_Rs2Valid,
    input  CorePkg::DecodeReg_t            i_DecodeReg,
    input  CorePkg::ExecReg_t              i_ExecReg,
    input  CorePkg::WbReg_t                i_Wb,
    output CorePkg::HazardCtl_t            o_Ctl
);

    logic rs1Busy;
    logic rs2Busy;
    logic stall;
    logic flush;

    // true when a source still waits on a write from execute, memory or writeback.
    function automatic logic srcBusy(
        input logic [CorePkg::REG_ADDR_W-1:0] addr,
        input logic                           addrValid
    );
        logic hitExec;
        logic hitMem;
        logic hitWb;
        hitExec = i_DecodeReg.valid && i_DecodeReg.writesReg && (i_DecodeReg.rd == addr);
        hitMem  = i_ExecReg.valid && i_ExecReg.writesReg && (i_ExecReg.rd == addr);
        hitWb   = i_Wb.valid && i_Wb.writesReg && (i_Wb.rd == addr);
        return addrValid && (addr != '0) && (hitExec || hitMem || hitWb);
    endfunction

    always_comb begin
        rs1Busy = srcBusy(i_Rs1Addr, i_Rs1Valid);
        rs2Busy = srcBusy(i_Rs2Addr, i_Rs2Valid);
    end

    assign stall = rs1Busy || rs2Busy;

    // branches resolve once they reach the memory stage.
    assign flush = i_ExecReg.valid && i_ExecReg.takeBranch;

    always_comb begin
        o_Ctl.pcEn         = 1'b1;
        o_Ctl.enFetchReg   = 1'b1;
        o_Ctl.enDecodeReg  = 1'b1;
        o_Ctl.clrFetchReg  = 1'b0;
        o_Ctl.clrDecodeReg = 1'b0;
        o_Ctl.clrExecReg   = 1'b0;
        if (flush) begin
            // the three younger instructions are all on the wrong path.
            o_Ctl.clrFetchReg  = 1'b1;
            o_Ctl.clrDecodeReg = 1'b1;
            o_Ctl.clrExecReg   = 1'b1;
        end else if (stall) begin
            o_Ctl.pcEn         = 1'b0;
            o_Ctl.enFetchReg   = 1'b0;
            o_Ctl.clrDecodeReg = 1'b1;
        end
    end

endmodule

//--- rtl/MemoryStage.sv
`timescale 1ns/1ps

module MemoryStage (
    input  logic              i_Clk,
    input  logic              i_rst,
    input  CorePkg::ExecReg_t i_ExecReg,
    output CorePkg::WbReg_t   o_Wb
);

    logic [CorePkg::XLEN-1:0]        dmem [CorePkg::DMEM_DEPTH];
    logic [CorePkg::DMEM_ADDR_W-1:0] wordAddr;

    assign wordAddr = i_ExecReg.aluResult[CorePkg::DMEM_ADDR_W+1:2];

    always_ff @(posedge i_Clk) begin
        if (i_ExecReg.valid && i_ExecReg.isStore) begin
            dmem[wordAddr] <= i_ExecReg.storeData;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            o_Wb <= '0;
        end else begin
            o_Wb.valid     <= i_ExecReg.valid;
            o_Wb.rd        <= i_ExecReg.rd;
            o_Wb.value     <= i_ExecReg.isLoad ? dmem[wordAddr] : i_ExecReg.aluResult;
            o_Wb.writesReg <= i_ExecReg.writesReg;
        end
    end

endmodule

//--- rtl/ExecuteStage.sv
`timescale 1ns/1ps

module ExecuteStage (
    input  logic                i_Clk,
    input  logic                i_rst,
    input  CorePkg::DecodeReg_t i_DecodeReg,
    input  CorePkg::HazardCtl_t i_Ctl,
    output CorePkg::ExecReg_t   o_ExecReg
);

    logic [CorePkg::XLEN-1:0] opB;
    logic [CorePkg::XLEN-1:0] aluResult;
    logic                     operandsEqual;

    assign opB           = i_DecodeReg.useImm ? i_DecodeReg.imm : i_DecodeReg.rs2Val;
    assign operandsEqual = (i_DecodeReg.rs1Val == i_DecodeReg.rs2Val);

    always_comb begin
        case (i_DecodeReg.aluOp)
            CorePkg::ALU_SUB: aluResult = i_DecodeReg.rs1Val - opB;
            CorePkg::ALU_AND: aluResult = i_DecodeReg.rs1Val & opB;
            CorePkg::ALU_OR:  aluResult = i_DecodeReg.rs1Val | opB;
            default:          aluResult = i_DecodeReg.rs1Val + opB;
        endcase
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst || i_Ctl.clrExecReg) begin
            o_ExecReg <= '0;
        end else begin
            o_ExecReg.valid        <= i_DecodeReg.valid;
            o_ExecReg.rd           <= i_DecodeReg.rd;
            o_ExecReg.aluResult    <= aluResult;
            o_ExecReg.storeData    <= i_DecodeReg.rs2Val;
            o_ExecReg.isLoad       <= i_DecodeReg.isLoad;
            o_ExecReg.isStore      <= i_DecodeReg.isStore;
            o_ExecReg.writesReg    <= i_DecodeReg.writesReg;
            o_ExecReg.takeBranch   <= i_DecodeReg.valid && i_DecodeReg.isBranch
                                      && operandsEqual;
            o_ExecReg.branchTarget <= i_DecodeReg.pc + i_DecodeReg.imm;
        end
    end

endmodule

//--- decode/DecodeStage.sv
`timescale 1ns/1ps

module DecodeStage (
    input  logic                           i_Clk,
    input  logic                           i_rst,
    input  CorePkg::FetchReg_t             i_FetchReg,
    input  CorePkg::HazardCtl_t            i_Ctl,
    input  CorePkg::WbReg_t                i_Wb,
    output logic [CorePkg::REG_ADDR_W-1:0] o_Rs1Addr,
    output logic                           o_Rs1Valid,
    output logic [CorePkg::REG_ADDR_W-1:0] o_Rs2Addr,
    output logic                           o_Rs2Valid,
    output CorePkg::DecodeReg_t            o_DecodeReg
);

    CorePkg::Instr_u          instr;
    CorePkg::DecodeReg_t      decodeNext;
    logic [CorePkg::XLEN-1:0] rs1Data;
    logic [CorePkg::XLEN-1:0] rs2Data;
    logic                     usesRs1;
    logic                     usesRs2;

    assign instr      = i_FetchReg.instr;
    assign o_Rs1Addr  = instr.r.rs1;
    assign o_Rs2Addr  = instr.r.rs2;
    assign o_Rs1Valid = i_FetchReg.valid && usesRs1;
    assign o_Rs2Valid = i_FetchReg.valid && usesRs2;

    RegFile RegFile_i (
        .i_Clk     (i_Clk),
        .i_rst     (i_rst),
        .i_Rs1Addr (instr.r.rs1),
        .i_Rs2Addr (instr.r.rs2),
        .i_Wb      (i_Wb),
        .o_Rs1Data (rs1Data),
        .o_Rs2Data (rs2Data)
    );

    always_comb begin
        decodeNext        = '0;
        decodeNext.valid  = i_FetchReg.valid;
        decodeNext.pc     = i_FetchReg.pc;
        decodeNext.rs1Val = rs1Data;
        decodeNext.rs2Val = rs2Data;
        decodeNext.rd     = instr.r.rd;
        decodeNext.aluOp  = CorePkg::ALU_ADD;
        usesRs1           = 1'b0;
        usesRs2           = 1'b0;
        case (instr.r.opcode)
            CorePkg::OP_RTYPE: begin
                usesRs1              = 1'b1;
                usesRs2              = 1'b1;
                decodeNext.writesReg = 1'b1;
                case (instr.r.funct3)
                    3'b111:  decodeNext.aluOp = CorePkg::ALU_AND;
                    3'b110:  decodeNext.aluOp = CorePkg::ALU_OR;
                    default: decodeNext.aluOp = instr.r.funct7[5] ? CorePkg::ALU_SUB
                                                                  : CorePkg::ALU_ADD;
                endcase
            end
            CorePkg::OP_ITYPE, CorePkg::OP_LOAD: begin
                usesRs1              = 1'b1;
                decodeNext.useImm    = 1'b1;
                decodeNext.writesReg = 1'b1;
                decodeNext.isLoad    = (instr.r.opcode == CorePkg::OP_LOAD);
                decodeNext.imm       = {{(CorePkg::XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end
            CorePkg::OP_STORE: begin
                usesRs1            = 1'b1;
                usesRs2            = 1'b1;
                decodeNext.useImm  = 1'b1;
                decodeNext.isStore = 1'b1;
                decodeNext.imm     = {{(CorePkg::XLEN-12){instr.s.immHi[6]}},
                                      instr.s.immHi, instr.s.immLo};
            end
            CorePkg::OP_BRANCH: begin
                usesRs1             = 1'b1;
                usesRs2             = 1'b1;
                decodeNext.isBranch = 1'b1;
                decodeNext.aluOp    = CorePkg::ALU_SUB;
                decodeNext.imm      = {{(CorePkg::XLEN-12){instr.b.imm12}}, instr.b.imm11,
                                       instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            end
            default: begin
                // anything outside the subset passes through as a no-op.
                decodeNext.writesReg = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst || i_Ctl.clrDecodeReg) begin
            o_DecodeReg <= '0;
        end else if (i_Ctl.enDecodeReg) begin
            o_DecodeReg <= decodeNext;
        end
    end

endmodule

//--- decode/RegFile.sv
`timescale 1ns/1ps

module RegFile (
    input  logic                           i_Clk,
    input  logic                           i_rst,
    input  logic [CorePkg::REG_ADDR_W-1:0] i_Rs1Addr,
    input  logic [CorePkg::REG_ADDR_W-1:0] i_Rs2Addr,
    input  CorePkg::WbReg_t                i_Wb,
    output logic [CorePkg::XLEN-1:0]       o_Rs1Data,
    output logic [CorePkg::XLEN-1:0]       o_Rs2Data
);

    // x0 has no storage and always reads as zero.
    logic [CorePkg::XLEN-1:0] regs [1:31];
    logic                     writeEn;

    assign writeEn = i_Wb.valid && i_Wb.writesReg && (i_Wb.rd != '0);

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            for (int idx = 1; idx < 32; idx++) begin
                regs[idx] <= '0;
            end
        end else if (writeEn) begin
            regs[i_Wb.rd] <= i_Wb.value;
        end
    end

    // reads return the value from before this cycle's write.
    assign o_Rs1Data = (i_Rs1Addr == '0) ? '0 : regs[i_Rs1Addr];
    assign o_Rs2Data = (i_Rs2Addr == '0) ? '0 : regs[i_Rs2Addr];

endmodule

//--- rtl/FetchStage.sv
`timescale 1ns/1ps

module FetchStage (
    input  logic                            i_Clk,
    input  logic                            i_rst,
    input  logic                            i_ImemWe,
    input  logic [CorePkg::IMEM_ADDR_W-1:0] i_ImemAddr,
    input  logic [CorePkg::XLEN-1:0]        i_ImemData,
    input  CorePkg::HazardCtl_t             i_Ctl,
    input  logic                            i_Redirect,
    input  logic [CorePkg::XLEN-1:0]        i_Target,
    output CorePkg::FetchReg_t              o_FetchReg
);

    logic [CorePkg::XLEN-1:0]        imem [CorePkg::IMEM_DEPTH];
    logic [CorePkg::XLEN-1:0]        pc;
    logic [CorePkg::IMEM_ADDR_W-1:0] fetchAddr;

    // the PC is a byte address, the memory holds words.
    assign fetchAddr = pc[CorePkg::IMEM_ADDR_W+1:2];

    always_ff @(posedge i_Clk) begin
        if (i_ImemWe) begin
            imem[i_ImemAddr] <= i_ImemData;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (i_Redirect) begin
            pc <= i_Target;
        end else if (i_Ctl.pcEn) begin
            pc <= pc + CorePkg::XLEN'(4);
        end
    end

    // the memory read lands directly in the fetch/decode register.
    always_ff @(posedge i_Clk) begin
        if (i_rst || i_Ctl.clrFetchReg) begin
            o_FetchReg <= '0;
        end else if (i_Ctl.enFetchReg) begin
            o_FetchReg.valid <= 1'b1;
            o_FetchReg.pc    <= pc;
            o_FetchReg.instr <= imem[fetchAddr];
        end
    end

endmodule

//--- common/CorePkg.sv
package CorePkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_DEPTH  = 256;
    localparam int DMEM_DEPTH  = 256;
    localparam int IMEM_ADDR_W = 8;
    localparam int DMEM_ADDR_W = 8;

    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } AluOp_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } RType_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } IType_t;

    typedef struct packed {
        logic [6:0]            immHi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            immLo;
        logic [6:0]            opcode;
    } SType_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10to5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4to1;
        logic                  imm11;
        logic [6:0]            opcode;
    } BType_t;

    // one instruction word, read in whichever format its opcode calls for.
    typedef union packed {
        RType_t r;
        IType_t i;
        SType_t s;
        BType_t b;
    } Instr_u;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } FetchReg_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1Val;
        logic [XLEN-1:0]       rs2Val;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        AluOp_t                aluOp;
        logic                  useImm;
        logic                  isLoad;
        logic                  isStore;
        logic                  isBranch;
        logic                  writesReg;
    } DecodeReg_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       storeData;
        logic                  isLoad;
        logic                  isStore;
        logic                  writesReg;
        logic                  takeBranch;
        logic [XLEN-1:0]       branchTarget;
    } ExecReg_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  writesReg;
    } WbReg_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } RetireInfo_t;

    typedef struct packed {
        logic pcEn;
        logic enFetchReg;
        logic enDecodeReg;
        logic clrFetchReg;
        logic clrDecodeReg;
        logic clrExecReg;
    } HazardCtl_t;

endpackage
